/* compile.f */
+incdir+test
logic/vstore_pkg.sv
logic/store_ctrl.sv
logic/lane_write_pack.sv
logic/bwe_sdp_ram.sv
logic/store_addr_gen.sv
logic/lane_read_select.sv
logic/vstore_buffer.sv
test/tb_vstore_buffer.sv

/* Bender.yml */
package:
  name: vstore_buffer

sources:
  - logic/vstore_pkg.sv
  - logic/store_ctrl.sv
  - logic/lane_write_pack.sv
  - logic/bwe_sdp_ram.sv
  - logic/store_addr_gen.sv
  - logic/lane_read_select.sv
  - logic/vstore_buffer.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_vstore_buffer.sv

/* test/vstore_model.svh */
/* Reference model of the store buffer bus output, the LFSR stimulus source
   and the expected-result queue. Included inside the testbench module */
`ifndef VSTORE_MODEL_SVH
`define VSTORE_MODEL_SVH

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
  } expect_t;

  expect_t     exp_q [$];               // One entry per accepted read
  logic [15:0] lfsr_state = 16'd59214;

  function automatic int unsigned elem_size(input vstore_pkg::sew_e s);
    case (s)
      vstore_pkg::SEW8:  return 1;
      vstore_pkg::SEW16: return 2;
      default:           return 4;
    endcase
  endfunction

  // Bus word for element r, built from the element's lane word
  function automatic expect_t ref_result(input vstore_pkg::sew_e s, input vstore_pkg::mode_e md,
                                         input logic [31:0] base_addr, input logic [31:0] step,
                                         input int unsigned r, input logic [31:0] lane_word);
    expect_t     e;
    logic [31:0] byte_addr;
    logic [31:0] value;
    logic [3:0]  smask;
    int unsigned nb;
    int unsigned sh;
    nb = elem_size(s);
    if (md == vstore_pkg::STRIDED) begin
      byte_addr = base_addr + r * step;
    end else begin
      byte_addr = base_addr + r * nb;
    end
    case (nb)
      1: begin
        value = lane_word & 32'h0000_00ff;
        smask = 4'b0001;
      end
      2: begin
        value = lane_word & 32'h0000_ffff;
        smask = 4'b0011;
      end
      default: begin
        value = lane_word;
        smask = 4'b1111;
      end
    endcase
    sh = byte_addr[1:0];
    e.addr = {byte_addr[31:2], 2'b00};
    e.data = value << (8 * sh);
    e.strb = smask << sh;
    return e;
  endfunction

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[15]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  function automatic void push_expect(input expect_t e);
    exp_q.push_back(e);
  endfunction

  function automatic expect_t pop_expect();
    return exp_q.pop_front();
  endfunction

  function automatic int pending_count();
    return exp_q.size();
  endfunction

`endif

/* test/tb_vstore_buffer.sv */
/* Testbench for vstore_buffer with 4 lanes and 16-word lane RAMs.
   Transfers are drained before each new configuration */
`default_nettype none
`timescale 1ns/1ps

module tb_vstore_buffer;

  localparam int LANES     = 4;
  localparam int DEPTH     = 16;
  localparam int ADDR_W    = 32;
  localparam int MAX_ELEMS = LANES * DEPTH * vstore_pkg::WORD_BYTES;
  localparam int CNT_W     = $clog2(MAX_ELEMS + 1);

  // Cycle budgets per test
  localparam int RESET_CYCLES   = 8;
  localparam int T1_LEN         = 4;
  localparam int T2_LEN         = 40;
  localparam int T3_LEN         = 100;
  localparam int T4_LEN         = 100;
  localparam int T5_LEN         = 90;
  localparam int TIMEOUT_CYCLES =
    2 * (T1_LEN + T2_LEN + T3_LEN + T4_LEN + T5_LEN) + RESET_CYCLES;

  logic               clk;
  logic               rstn;
  logic               cfg_load;
  vstore_pkg::sew_e   sew;
  vstore_pkg::mode_e  mode;
  logic [ADDR_W-1:0]  base;
  logic [ADDR_W-1:0]  stride;
  logic [CNT_W-1:0]   vl;
  logic               wr_en;
  vstore_pkg::word_t  lane_data [LANES];
  logic               rd_en;
  logic               out_valid;
  logic [ADDR_W-1:0]  out_addr;
  vstore_pkg::word_t  out_data;
  vstore_pkg::strb_t  out_strb;
  logic               wr_done;
  logic               rd_done;
  logic               not_empty;

  `include "vstore_model.svh"

  // Model of the configured transfer
  vstore_pkg::sew_e   m_sew;
  vstore_pkg::mode_e  m_mode;
  logic [31:0]        m_base;
  logic [31:0]        m_stride;
  int unsigned        m_vl = 0;
  int unsigned        m_wr_pulses = 0;
  int unsigned        m_rd_reqs = 0;
  bit                 m_wr_done = 1'b0;
  bit                 m_rd_done = 1'b0;
  logic [31:0]        elem_words [MAX_ELEMS];   // Lane word of each global element

  int err_cnt = 0;
  int check_cnt = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int test_err_start = 0;
  int cycle_cnt;

  vstore_buffer #(
    .LANES  (LANES),
    .DEPTH  (DEPTH),
    .ADDR_W (ADDR_W)
  ) DUT (
    .clk         (clk),
    .rstn        (rstn),
    .cfg_load_i  (cfg_load),
    .sew_i       (sew),
    .mode_i      (mode),
    .base_i      (base),
    .stride_i    (stride),
    .vl_i        (vl),
    .wr_en_i     (wr_en),
    .lane_data_i (lane_data),
    .rd_en_i     (rd_en),
    .out_valid_o (out_valid),
    .out_addr_o  (out_addr),
    .out_data_o  (out_data),
    .out_strb_o  (out_strb),
    .wr_done_o   (wr_done),
    .rd_done_o   (rd_done),
    .not_empty_o (not_empty)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Checking helpers
  ////////////////////////////////////////////////////////////
  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Mismatch %s at %0t: got %0h expected %0h", name, $time, got, exp);
    end
  endtask

  task automatic note_failure(input string msg);
    err_cnt++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  task automatic start_test();
    test_err_start = err_cnt;
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = err_cnt - test_err_start;
    tests_run++;
    if (errs == 0) begin
      $display("Test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: %0d errors", tests_run, name, errs);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////
  task automatic configure(input vstore_pkg::sew_e s, input vstore_pkg::mode_e md,
                           input logic [31:0] b, input logic [31:0] st,
                           input int unsigned n);
    @(posedge clk);
    cfg_load <= 1'b1;
    sew      <= s;
    mode     <= md;
    base     <= b;
    stride   <= st;
    vl       <= CNT_W'(n);
    wr_en    <= 1'b0;
    rd_en    <= 1'b0;
    m_sew       = s;
    m_mode      = md;
    m_base      = b;
    m_stride    = st;
    m_vl        = n;
    m_wr_pulses = 0;
    m_rd_reqs   = 0;
    m_wr_done   = 1'b0;
    m_rd_done   = 1'b0;
  endtask

  // One clock of pulses; flags are checked against the state before them
  task automatic drive_cycle(input bit do_wr, input bit do_rd);
    bit          exp_wr_done;
    bit          exp_rd_done;
    bit          exp_not_empty;
    int unsigned written;
    int unsigned k;
    logic [31:0] word;
    written = m_wr_pulses * LANES;
    if (written > m_vl) begin
      written = m_vl;
    end
    exp_wr_done   = m_wr_done;
    exp_rd_done   = m_rd_done;
    exp_not_empty = (written > m_rd_reqs);
    @(posedge clk);
    cfg_load <= 1'b0;
    wr_en    <= do_wr;
    rd_en    <= do_rd;
    if (do_rd && (m_rd_reqs < written)) begin   // Read accepted
      push_expect(ref_result(m_sew, m_mode, m_base, m_stride, m_rd_reqs,
                             elem_words[m_rd_reqs]));
      m_rd_reqs++;
      if (m_rd_reqs == m_vl) begin
        m_rd_done = 1'b1;
      end
    end
    if (do_wr) begin
      for (int l = 0; l < LANES; l++) begin
        word = take_bits(32);
        k = m_wr_pulses * LANES + l;
        lane_data[l] <= word;
        if (k < MAX_ELEMS) begin
          elem_words[k] = word;
        end
      end
      m_wr_pulses++;
      if (m_wr_pulses * LANES >= m_vl) begin
        m_wr_done = 1'b1;
      end
    end
    @(negedge clk);
    compare_value("wr_done_o", 32'(wr_done), 32'(exp_wr_done));
    compare_value("rd_done_o", 32'(rd_done), 32'(exp_rd_done));
    compare_value("not_empty_o", 32'(not_empty), 32'(exp_not_empty));
  endtask

  // Waits for pending outputs, then a few idle cycles for stray ones
  task automatic drain_outputs();
    int n;
    n = 0;
    while ((pending_count() != 0) && (n < 10)) begin
      drive_cycle(1'b0, 1'b0);
      n++;
    end
    repeat (3) drive_cycle(1'b0, 1'b0);
    if (pending_count() != 0) begin
      note_failure($sformatf("%0d expected outputs never appeared", pending_count()));
      exp_q.delete();
    end
  endtask

  task automatic run_transfer(input vstore_pkg::sew_e s, input vstore_pkg::mode_e md,
                              input logic [31:0] b, input logic [31:0] st,
                              input int unsigned n, input bit interleave);
    configure(s, md, b, st, n);
    if (interleave) begin
      while (m_rd_reqs < n) begin
        drive_cycle(!m_wr_done, 1'b1);
      end
    end else begin
      while (!m_wr_done) begin
        drive_cycle(1'b1, 1'b0);
      end
      while (m_rd_reqs < n) begin
        drive_cycle(1'b0, 1'b1);
      end
    end
    drain_outputs();
  endtask

  // Output comparison
  initial begin : compare_outputs
    expect_t e;
    forever begin
      @(negedge clk);
      if (rstn && out_valid) begin
        if (pending_count() == 0) begin
          note_failure("bus output appeared with no accepted read pending");
        end else begin
          e = pop_expect();
          compare_value("out_addr_o", out_addr, e.addr);
          compare_value("out_data_o", out_data, e.data);
          compare_value("out_strb_o", 32'(out_strb), 32'(e.strb));
        end
      end
    end
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Run timed out after %0d cycles", cycle_cnt);
    $display("SIMULATION FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////
  initial begin : main
    int unsigned nb;
    rstn     = 1'b0;
    cfg_load = 1'b0;
    sew      = vstore_pkg::SEW8;
    mode     = vstore_pkg::UNIT;
    base     = '0;
    stride   = '0;
    vl       = '0;
    wr_en    = 1'b0;
    rd_en    = 1'b0;
    for (int l = 0; l < LANES; l++) begin
      lane_data[l] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    rstn <= 1'b1;

    start_test();
    @(negedge clk);
    compare_value("out_valid_o", 32'(out_valid), 32'd0);
    compare_value("wr_done_o", 32'(wr_done), 32'd0);
    compare_value("rd_done_o", 32'(rd_done), 32'd0);
    compare_value("not_empty_o", 32'(not_empty), 32'd0);
    finish_test("reset state");

    start_test();
    run_transfer(vstore_pkg::SEW32, vstore_pkg::UNIT, 32'h0000_1000, 32'd0, 16, 1'b0);
    finish_test("unit SEW32 back-to-back");

    // Base one element past the word start
    start_test();
    run_transfer(vstore_pkg::SEW16, vstore_pkg::UNIT, 32'h0000_2002, 32'd0, 24, 1'b0);
    run_transfer(vstore_pkg::SEW8, vstore_pkg::UNIT, 32'h0000_3001, 32'd0, 37, 1'b1);
    finish_test("unit SEW16 and SEW8 offset base");

    start_test();
    nb = elem_size(vstore_pkg::SEW32);
    run_transfer(vstore_pkg::SEW32, vstore_pkg::STRIDED, take_bits(16) * nb,
                 (take_bits(5) + 1) * nb, 12, 1'b0);
    nb = elem_size(vstore_pkg::SEW16);
    run_transfer(vstore_pkg::SEW16, vstore_pkg::STRIDED, take_bits(16) * nb,
                 (take_bits(5) + 1) * nb, 12, 1'b1);
    nb = elem_size(vstore_pkg::SEW8);
    run_transfer(vstore_pkg::SEW8, vstore_pkg::STRIDED, take_bits(16) * nb,
                 (take_bits(5) + 1) * nb, 12, 1'b1);
    finish_test("strided random strides");

    // Reads before data, spaced reads, extra reads after the last one
    start_test();
    configure(vstore_pkg::SEW16, vstore_pkg::UNIT, 32'h0000_4000, 32'd0, 10);
    repeat (3) drive_cycle(1'b0, 1'b1);
    drive_cycle(1'b1, 1'b0);
    for (int i = 0; i < 6; i++) begin
      drive_cycle(1'b0, 1'b1);
      repeat (i % 3) drive_cycle(1'b0, 1'b0);
    end
    drive_cycle(1'b1, 1'b0);
    drive_cycle(1'b1, 1'b0);
    for (int i = 0; i < 8; i++) begin
      drive_cycle(1'b0, 1'b1);
      repeat (2) drive_cycle(1'b0, 1'b0);
    end
    repeat (4) drive_cycle(1'b0, 1'b1);
    drain_outputs();
    // All ten elements written and requested by now
    compare_value("wr_done_o", 32'(wr_done), 32'd1);
    compare_value("rd_done_o", 32'(rd_done), 32'd1);
    compare_value("not_empty_o", 32'(not_empty), 32'd0);
    finish_test("spaced and ignored pulses");

    $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* logic/vstore_buffer.sv */
/* Vector store buffer between the vector lanes and a memory write port.
   LANES and DEPTH must be powers of two; there is no back-pressure */
`default_nettype none
`timescale 1ns/1ps

module vstore_buffer #(
  parameter  int LANES  = 4,
  parameter  int DEPTH  = 16,
  parameter  int ADDR_W = 32,
  localparam int CNT_W  = $clog2(LANES*DEPTH*vstore_pkg::WORD_BYTES + 1)
) (
  input  logic                clk,
  input  logic                rstn,
  input  logic                cfg_load_i,
  input  vstore_pkg::sew_e    sew_i,
  input  vstore_pkg::mode_e   mode_i,
  input  logic [ADDR_W-1:0]   base_i,
  input  logic [ADDR_W-1:0]   stride_i,
  input  logic [CNT_W-1:0]    vl_i,
  input  logic                wr_en_i,
  input  vstore_pkg::word_t   lane_data_i [LANES],
  input  logic                rd_en_i,
  output logic                out_valid_o,
  output logic [ADDR_W-1:0]   out_addr_o,
  output vstore_pkg::word_t   out_data_o,
  output vstore_pkg::strb_t   out_strb_o,
  output logic                wr_done_o,
  output logic                rd_done_o,
  output logic                not_empty_o
);

  localparam int AW = $clog2(DEPTH);
  localparam int LW = $clog2(LANES);

  vstore_pkg::sew_e   sew;
  logic               wr_accept;
  logic [AW-1:0]      wr_addr;
  logic [1:0]         wr_slot;
  logic               rd_accept;
  logic [AW-1:0]      rd_addr;
  logic [LW-1:0]      sel_lane;
  logic [1:0]         sel_slot;
  logic               sel_valid;
  vstore_pkg::word_t  ram_wdata [LANES];
  vstore_pkg::strb_t  ram_be;
  vstore_pkg::word_t  ram_rdata [LANES];
  logic [ADDR_W-1:0]  elem_addr;
  logic [1:0]         elem_offset;

  store_ctrl #(
    .LANES (LANES),
    .DEPTH (DEPTH),
    .CNT_W (CNT_W)
  ) u_ctrl (
    .clk         (clk),
    .rstn        (rstn),
    .cfg_load_i  (cfg_load_i),
    .sew_i       (sew_i),
    .vl_i        (vl_i),
    .wr_en_i     (wr_en_i),
    .rd_en_i     (rd_en_i),
    .sew_o       (sew),
    .wr_accept_o (wr_accept),
    .wr_addr_o   (wr_addr),
    .wr_slot_o   (wr_slot),
    .rd_accept_o (rd_accept),
    .rd_addr_o   (rd_addr),
    .rd_elem_o   (),
    .sel_lane_o  (sel_lane),
    .sel_slot_o  (sel_slot),
    .sel_valid_o (sel_valid),
    .wr_done_o   (wr_done_o),
    .rd_done_o   (rd_done_o),
    .not_empty_o (not_empty_o)
  );

  lane_write_pack #(.LANES(LANES)) u_pack (
    .sew_i       (sew),
    .slot_i      (wr_slot),
    .accept_i    (wr_accept),
    .lane_data_i (lane_data_i),
    .ram_wdata_o (ram_wdata),
    .ram_be_o    (ram_be)
  );

  ////////////////////////////////////////////////////////////
  // One RAM per lane, all on the same addresses
  ////////////////////////////////////////////////////////////
  for (genvar l = 0; l < LANES; l++) begin : g_lane_ram
    bwe_sdp_ram #(.DEPTH(DEPTH)) u_ram (
      .clk     (clk),
      .we_i    (ram_be),
      .waddr_i (wr_addr),
      .wdata_i (ram_wdata[l]),
      .re_i    (rd_accept),
      .raddr_i (rd_addr),
      .rdata_o (ram_rdata[l])
    );
  end

  store_addr_gen #(.ADDR_W(ADDR_W)) u_addr (
    .clk        (clk),
    .rstn       (rstn),
    .cfg_load_i (cfg_load_i),
    .mode_i     (mode_i),
    .sew_i      (sew_i),
    .base_i     (base_i),
    .stride_i   (stride_i),
    .accept_i   (rd_accept),
    .addr_o     (elem_addr),
    .offset_o   (elem_offset)
  );

  lane_read_select #(
    .LANES  (LANES),
    .ADDR_W (ADDR_W)
  ) u_select (
    .clk         (clk),
    .rstn        (rstn),
    .sew_i       (sew),
    .ram_rdata_i (ram_rdata),
    .lane_i      (sel_lane),
    .slot_i      (sel_slot),
    .valid_i     (sel_valid),
    .offset_i    (elem_offset),
    .addr_i      (elem_addr),
    .out_valid_o (out_valid_o),
    .out_addr_o  (out_addr_o),
    .out_data_o  (out_data_o),
    .out_strb_o  (out_strb_o)
  );

endmodule

`default_nettype wire

/* logic/lane_read_select.sv */
/* Picks the element from the lane RAM words, aligns it to the bus address
   and registers the bus outputs. Elements must not cross a word boundary */
`default_nettype none
`timescale 1ns/1ps

module lane_read_select #(
  parameter int LANES  = 4,
  parameter int ADDR_W = 32
) (
  input  logic                       clk,
  input  logic                       rstn,
  input  vstore_pkg::sew_e           sew_i,
  input  vstore_pkg::word_t          ram_rdata_i [LANES],
  input  logic [$clog2(LANES)-1:0]   lane_i,
  input  logic [1:0]                 slot_i,
  input  logic                       valid_i,
  input  logic [1:0]                 offset_i,
  input  logic [ADDR_W-1:0]          addr_i,
  output logic                       out_valid_o,
  output logic [ADDR_W-1:0]          out_addr_o,
  output vstore_pkg::word_t          out_data_o,
  output vstore_pkg::strb_t          out_strb_o
);

  vstore_pkg::word_t lane_word;
  vstore_pkg::word_t elem_low;   // Slot moved down to byte 0
  vstore_pkg::word_t elem;
  vstore_pkg::word_t elem_rot;
  vstore_pkg::strb_t elem_mask;
  vstore_pkg::strb_t strb_rot;
  logic [4:0]        rot_bits;

  assign lane_word = ram_rdata_i[lane_i];
  assign elem_low  = lane_word >> {slot_i, 3'b000};

  // Clear the bytes above the element
  always_comb begin
    case (sew_i)
      vstore_pkg::SEW8:  elem = {24'b0, elem_low[7:0]};
      vstore_pkg::SEW16: elem = {16'b0, elem_low[15:0]};
      default:           elem = elem_low;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Rotate to the byte lane of the address
  ////////////////////////////////////////////////////////////
  assign rot_bits = {offset_i, 3'b000};
  assign elem_rot = (elem << rot_bits) | (elem >> (6'd32 - rot_bits));

  assign elem_mask = vstore_pkg::strb_t'((1 << vstore_pkg::elem_bytes(sew_i)) - 1);
  assign strb_rot  = (elem_mask << offset_i) | (elem_mask >> (3'd4 - offset_i));

  always_ff @(posedge clk) begin
    if (!rstn) begin
      out_valid_o <= 1'b0;
    end else begin
      out_valid_o <= valid_i;
    end
  end

  // Payload holds the last element between reads
  always_ff @(posedge clk) begin
    if (valid_i) begin
      out_addr_o <= addr_i;
      out_data_o <= elem_rot;
      out_strb_o <= strb_rot;
    end
  end

endmodule

`default_nettype wire

/* logic/store_addr_gen.sv */
/* Byte address of each read element, unit-stride or strided.
   Base and stride must be multiples of the element size */
`default_nettype none
`timescale 1ns/1ps

module store_addr_gen #(
  parameter int ADDR_W = 32
) (
  input  logic                clk,
  input  logic                rstn,
  input  logic                cfg_load_i,
  input  vstore_pkg::mode_e   mode_i,
  input  vstore_pkg::sew_e    sew_i,
  input  logic [ADDR_W-1:0]   base_i,
  input  logic [ADDR_W-1:0]   stride_i,
  input  logic                accept_i,
  output logic [ADDR_W-1:0]   addr_o,
  output logic [1:0]          offset_o
);

  logic [ADDR_W-1:0] ebytes;
  logic [ADDR_W-1:0] step_q;    // Bytes between elements
  logic [ADDR_W-1:0] cur_q;     // Address of the next element
  logic [ADDR_W-1:0] addr_q;

  assign ebytes = ADDR_W'(vstore_pkg::elem_bytes(sew_i));

  always_ff @(posedge clk) begin
    if (!rstn) begin
      step_q <= '0;
      cur_q  <= '0;
      addr_q <= '0;
    end else if (cfg_load_i) begin
      step_q <= (mode_i == vstore_pkg::STRIDED) ? stride_i : ebytes;
      cur_q  <= base_i;
    end else if (accept_i) begin
      cur_q  <= cur_q + step_q;
      addr_q <= cur_q;          // Aligned with the RAM read data
    end
  end

  assign addr_o   = {addr_q[ADDR_W-1:2], 2'b00};
  assign offset_o = addr_q[1:0];

  // Elements never straddle a bus word
  a_cfg_aligned: assert property (@(posedge clk) disable iff (!rstn)
    cfg_load_i |-> ((base_i & (ebytes - 1'b1)) == '0) &&
                   ((mode_i == vstore_pkg::UNIT) || ((stride_i & (ebytes - 1'b1)) == '0)));

endmodule

`default_nettype wire

/* logic/bwe_sdp_ram.sv */
/* Byte-write simple dual-port RAM with a registered read port.
   Reading a word written in the same cycle returns the old contents */
`default_nettype none
`timescale 1ns/1ps

module bwe_sdp_ram #(
  parameter int DEPTH = 16
) (
  input  logic                       clk,
  input  vstore_pkg::strb_t          we_i,
  input  logic [$clog2(DEPTH)-1:0]   waddr_i,
  input  vstore_pkg::word_t          wdata_i,
  input  logic                       re_i,
  input  logic [$clog2(DEPTH)-1:0]   raddr_i,
  output vstore_pkg::word_t          rdata_o
);

  vstore_pkg::word_t mem [DEPTH];

  // One enable per byte column
  always_ff @(posedge clk) begin
    for (int b = 0; b < vstore_pkg::WORD_BYTES; b++) begin
      if (we_i[b]) begin
        mem[waddr_i][8*b +: 8] <= wdata_i[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (re_i) begin
      rdata_o <= mem[raddr_i];
    end
  end

endmodule

`default_nettype wire

/* logic/lane_write_pack.sv */
/* Packs one element per lane into a RAM word. Only the low element of each
   lane word is used; the byte enable is common to all lanes */
`default_nettype none
`timescale 1ns/1ps

module lane_write_pack #(
  parameter int LANES = 4
) (
  input  vstore_pkg::sew_e  sew_i,
  input  logic [1:0]        slot_i,
  input  logic              accept_i,
  input  vstore_pkg::word_t lane_data_i [LANES],
  output vstore_pkg::word_t ram_wdata_o [LANES],
  output vstore_pkg::strb_t ram_be_o
);

  vstore_pkg::strb_t elem_mask;

  // Replicate the element so every slot sees it
  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      case (sew_i)
        vstore_pkg::SEW8:  ram_wdata_o[l] = {4{lane_data_i[l][7:0]}};
        vstore_pkg::SEW16: ram_wdata_o[l] = {2{lane_data_i[l][15:0]}};
        default:           ram_wdata_o[l] = lane_data_i[l];
      endcase
    end
  end

  assign elem_mask = vstore_pkg::strb_t'((1 << vstore_pkg::elem_bytes(sew_i)) - 1);

  // Enables only the slot's bytes
  assign ram_be_o = accept_i ? (elem_mask << slot_i) : '0;

endmodule

`default_nettype wire

/* logic/store_ctrl.sv */
/* Counters, acceptance and status of the store buffer. LANES and DEPTH must
   be powers of two, at least 2. Pulses during cfg_load_i are ignored */
`default_nettype none
`timescale 1ns/1ps

module store_ctrl #(
  parameter int LANES = 4,
  parameter int DEPTH = 16,
  parameter int CNT_W = 9
) (
  input  logic                       clk,
  input  logic                       rstn,
  input  logic                       cfg_load_i,
  input  vstore_pkg::sew_e           sew_i,
  input  logic [CNT_W-1:0]           vl_i,
  input  logic                       wr_en_i,
  input  logic                       rd_en_i,
  output vstore_pkg::sew_e           sew_o,
  output logic                       wr_accept_o,
  output logic [$clog2(DEPTH)-1:0]   wr_addr_o,
  output logic [1:0]                 wr_slot_o,
  output logic                       rd_accept_o,
  output logic [$clog2(DEPTH)-1:0]   rd_addr_o,
  output logic [CNT_W-1:0]           rd_elem_o,
  output logic [$clog2(LANES)-1:0]   sel_lane_o,
  output logic [1:0]                 sel_slot_o,
  output logic                       sel_valid_o,
  output logic                       wr_done_o,
  output logic                       rd_done_o,
  output logic                       not_empty_o
);

  localparam int AW = $clog2(DEPTH);
  localparam int LW = $clog2(LANES);

  vstore_pkg::sew_e   sew_q;
  logic [CNT_W-1:0]   vl_q;
  logic [CNT_W-1:0]   wr_cnt;       // Write pulses taken
  logic [CNT_W-1:0]   rd_cnt;       // Next element to read
  logic [CNT_W-1:0]   wr_elems;
  logic [CNT_W-1:0]   wr_elems_nxt;
  logic [CNT_W-1:0]   wr_word;
  logic [CNT_W-1:0]   rd_pulse;
  logic [CNT_W-1:0]   rd_word;
  logic [1:0]         sew_shift;
  logic               wr_done_q;
  logic               rd_done_q;
  logic               rd_avail;
  logic               sel_valid_q;
  logic [LW-1:0]      sel_lane_q;
  logic [1:0]         sel_slot_q;

  // Byte offset of pulse k's element inside its word
  function automatic logic [1:0] slot_of(input logic [CNT_W-1:0] k,
                                         input vstore_pkg::sew_e sew);
    int unsigned epw;
    epw = vstore_pkg::elems_per_word(sew);
    return 2'((32'(k[1:0]) & (epw - 1)) * vstore_pkg::elem_bytes(sew));
  endfunction

  always_comb begin
    case (sew_q)
      vstore_pkg::SEW8:  sew_shift = 2'd2;
      vstore_pkg::SEW16: sew_shift = 2'd1;
      default:           sew_shift = 2'd0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Acceptance and addressing
  ////////////////////////////////////////////////////////////
  assign wr_elems     = wr_cnt << LW;
  assign wr_elems_nxt = (wr_cnt + 1'b1) << LW;
  assign rd_avail     = (rd_cnt < vl_q) && (rd_cnt < wr_elems);

  assign wr_accept_o = wr_en_i && !wr_done_q && !cfg_load_i;
  assign rd_accept_o = rd_en_i && rd_avail && !cfg_load_i;

  assign wr_word   = wr_cnt >> sew_shift;
  assign wr_addr_o = wr_word[AW-1:0];
  assign wr_slot_o = slot_of(wr_cnt, sew_q);

  assign rd_pulse  = rd_cnt >> LW;          // Write pulse that stored it
  assign rd_word   = rd_pulse >> sew_shift;
  assign rd_addr_o = rd_word[AW-1:0];
  assign rd_elem_o = rd_cnt;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      sew_q     <= vstore_pkg::SEW8;
      vl_q      <= '0;
      wr_cnt    <= '0;
      rd_cnt    <= '0;
      wr_done_q <= 1'b0;
      rd_done_q <= 1'b0;
    end else if (cfg_load_i) begin
      sew_q     <= sew_i;
      vl_q      <= vl_i;
      wr_cnt    <= '0;
      rd_cnt    <= '0;
      wr_done_q <= 1'b0;
      rd_done_q <= 1'b0;
    end else begin
      if (wr_accept_o) begin
        wr_cnt <= wr_cnt + 1'b1;
        if (wr_elems_nxt >= vl_q) begin
          wr_done_q <= 1'b1;    // Last pulse covers vl
        end
      end
      if (rd_accept_o) begin
        rd_cnt <= rd_cnt + 1'b1;
        if (rd_cnt + 1'b1 == vl_q) begin
          rd_done_q <= 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Select fields, aligned with the RAM read data
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      sel_valid_q <= 1'b0;
    end else begin
      sel_valid_q <= rd_accept_o;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_accept_o) begin
      sel_lane_q <= rd_cnt[LW-1:0];
      sel_slot_q <= slot_of(rd_pulse, sew_q);
    end
  end

  assign sew_o       = sew_q;
  assign sel_valid_o = sel_valid_q;
  assign sel_lane_o  = sel_lane_q;
  assign sel_slot_o  = sel_slot_q;
  assign wr_done_o   = wr_done_q;
  assign rd_done_o   = rd_done_q;
  assign not_empty_o = rd_avail;    // Written and not yet requested

  // Writer stops once the whole vector is in
  a_no_wr_after_done: assert property (@(posedge clk) disable iff (!rstn)
    (wr_en_i && !cfg_load_i) |-> !wr_done_o);

  a_rd_addr_range: assert property (@(posedge clk) disable iff (!rstn)
    rd_accept_o |-> (rd_word < CNT_W'(DEPTH)));

endmodule

`default_nettype wire

/* logic/vstore_pkg.sv */
/* Shared word, strobe and element types of the vector store buffer.
   Words are 32 bits wide and elements are 8, 16 or 32 bits wide */
`default_nettype none

package vstore_pkg;

  localparam int WORD_BYTES = 4; // Bytes per buffer and bus word

  typedef logic [8*WORD_BYTES-1:0] word_t;
  typedef logic [WORD_BYTES-1:0]   strb_t;

  // Element width
  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_e;

  typedef enum logic {
    UNIT    = 1'b0,
    STRIDED = 1'b1
  } mode_e;

  function automatic int unsigned elem_bytes(input sew_e sew);
    case (sew)
      SEW8:    return 1;
      SEW16:   return 2;
      default: return 4;
    endcase
  endfunction

  // Elements of one width packed into one word
  function automatic int unsigned elems_per_word(input sew_e sew);
    return WORD_BYTES / elem_bytes(sew);
  endfunction

endpackage

`default_nettype wire
